// File: include/calc_defines.svh
// calculator core widths and entry radix
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// sign-magnitude word, sign bit on top
`define CALC_DATA_W 16
`define CALC_MAG_W (`CALC_DATA_W - 1)

// one keypad digit and the base it is entered in
`define CALC_DIGIT_W 4
`define CALC_RADIX 10

`endif

// File: hdl/calc_key_pkg.sv
// keypad-side types for the calculator core: operator codes and entry states
package calc_key_pkg;

    // one-cycle operator code from the keypad
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_code_e;

    // entry and sequencing FSM states
    typedef enum logic [3:0] {
        ENTER_A, SCALE_A, ACCUM_A,
        ENTER_B, SCALE_B, ACCUM_B,
        ISSUE, WAIT_RESULT, SHOW
    } entry_state_e;

endpackage

// File: hdl/calc_arith_pkg.sv
// arithmetic-side types for the calculator core: words, requests, unit select
`include "calc_defines.svh"

package calc_arith_pkg;

    // sign-magnitude number, zero is always positive on results
    typedef struct packed {
        logic                   sign;
        logic [`CALC_MAG_W-1:0] mag;
    } sm_word_t;

    // request bus shared by the adder and the multiplier
    typedef struct packed {
        sm_word_t a;
        sm_word_t b;
        logic     sub;  // adder only, flips b
    } arith_req_t;

    // unit the controller waits on
    typedef enum logic {
        UNIT_ADDSUB = 1'b0,
        UNIT_MUL    = 1'b1
    } unit_sel_e;

endpackage

// File: hdl/calc_entry_ctrl.sv
// calculator entry FSM: builds operands from digits, issues requests, latches results
`include "calc_defines.svh"

module calc_entry_ctrl (
    input  logic                       clk,
    input  logic                       nRST,
    input  logic                       key_strobe,
    input  logic [`CALC_DIGIT_W-1:0]   key_digit,
    input  calc_key_pkg::op_code_e     op_code,
    input  logic                       equal_strobe,
    input  calc_arith_pkg::sm_word_t   sum,
    input  logic                       addsub_done,
    input  calc_arith_pkg::sm_word_t   product,
    input  logic                       mul_done,
    output calc_arith_pkg::arith_req_t req,
    output logic                       start_addsub,
    output logic                       start_mul,
    output calc_arith_pkg::sm_word_t   result,
    output logic                       complete,
    output logic                       busy
);

    // multiplier operand used to scale by the radix
    localparam calc_arith_pkg::sm_word_t RADIX_WORD = '{sign: 1'b0, mag: `CALC_RADIX};

    calc_key_pkg::entry_state_e state, next_state;

    calc_arith_pkg::sm_word_t  operand_a, operand_b;
    calc_key_pkg::op_code_e    pend_op;
    calc_arith_pkg::unit_sel_e wait_unit;
    logic [`CALC_DIGIT_W-1:0]  digit_q;
    logic [`CALC_MAG_W-1:0]    digit_ext;
    logic                      is_binop;
    logic                      done_awaited;

    assign digit_ext = {{(`CALC_MAG_W - `CALC_DIGIT_W){1'b0}}, digit_q};
    assign is_binop  = (op_code == calc_key_pkg::OP_ADD) ||
                       (op_code == calc_key_pkg::OP_SUB) ||
                       (op_code == calc_key_pkg::OP_MUL);
    assign done_awaited = (wait_unit == calc_arith_pkg::UNIT_MUL) ? mul_done : addsub_done;

    // keypad accepted only in the two entry states
    assign busy = (state != calc_key_pkg::ENTER_A) && (state != calc_key_pkg::ENTER_B);

    always_comb begin
        next_state = state;
        case (state)
            calc_key_pkg::ENTER_A: begin
                if (key_strobe)
                    next_state = calc_key_pkg::SCALE_A;
                else if (is_binop)
                    next_state = calc_key_pkg::ENTER_B;
            end
            calc_key_pkg::SCALE_A:
                if (mul_done) next_state = calc_key_pkg::ACCUM_A;
            calc_key_pkg::ACCUM_A:
                next_state = calc_key_pkg::ENTER_A;
            calc_key_pkg::ENTER_B: begin
                if (key_strobe)
                    next_state = calc_key_pkg::SCALE_B;
                else if (equal_strobe)
                    next_state = calc_key_pkg::ISSUE;
            end
            calc_key_pkg::SCALE_B:
                if (mul_done) next_state = calc_key_pkg::ACCUM_B;
            calc_key_pkg::ACCUM_B:
                next_state = calc_key_pkg::ENTER_B;
            calc_key_pkg::ISSUE:
                next_state = calc_key_pkg::WAIT_RESULT;
            calc_key_pkg::WAIT_RESULT:
                if (done_awaited) next_state = calc_key_pkg::SHOW;
            calc_key_pkg::SHOW:
                next_state = calc_key_pkg::ENTER_A;
            default:
                next_state = calc_key_pkg::ENTER_A;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state        <= calc_key_pkg::ENTER_A;
            operand_a    <= '0;
            operand_b    <= '0;
            pend_op      <= calc_key_pkg::OP_NONE;
            wait_unit    <= calc_arith_pkg::UNIT_ADDSUB;
            start_addsub <= 1'b0;
            start_mul    <= 1'b0;
            result       <= '0;
            complete     <= 1'b0;
        end else begin
            state        <= next_state;
            start_addsub <= 1'b0;
            start_mul    <= 1'b0;
            complete     <= 1'b0;
            case (state)
                calc_key_pkg::ENTER_A: begin
                    if (key_strobe)
                        start_mul <= 1'b1;
                    else if (op_code == calc_key_pkg::OP_NEG)
                        operand_a.sign <= ~operand_a.sign;
                    else if (is_binop)
                        pend_op <= op_code;
                end
                // sign is kept, only the magnitude is scaled
                calc_key_pkg::SCALE_A:
                    if (mul_done) operand_a.mag <= product.mag;
                calc_key_pkg::ACCUM_A:
                    operand_a.mag <= operand_a.mag + digit_ext;
                calc_key_pkg::ENTER_B: begin
                    if (key_strobe)
                        start_mul <= 1'b1;
                    else if (op_code == calc_key_pkg::OP_NEG)
                        operand_b.sign <= ~operand_b.sign;
                end
                calc_key_pkg::SCALE_B:
                    if (mul_done) operand_b.mag <= product.mag;
                calc_key_pkg::ACCUM_B:
                    operand_b.mag <= operand_b.mag + digit_ext;
                calc_key_pkg::ISSUE: begin
                    if (pend_op == calc_key_pkg::OP_MUL) begin
                        start_mul <= 1'b1;
                        wait_unit <= calc_arith_pkg::UNIT_MUL;
                    end else begin
                        start_addsub <= 1'b1;
                        wait_unit    <= calc_arith_pkg::UNIT_ADDSUB;
                    end
                end
                // result and complete become visible together in SHOW
                calc_key_pkg::WAIT_RESULT: begin
                    if (done_awaited) begin
                        result   <= (wait_unit == calc_arith_pkg::UNIT_MUL) ? product : sum;
                        complete <= 1'b1;
                    end
                end
                calc_key_pkg::SHOW: begin
                    operand_a <= '0;
                    operand_b <= '0;
                    pend_op   <= calc_key_pkg::OP_NONE;
                end
                default: ;
            endcase
        end
    end

    // request bus and latched digit
    always_ff @(posedge clk) begin
        case (state)
            calc_key_pkg::ENTER_A: begin
                if (key_strobe) begin
                    digit_q <= key_digit;
                    req.a   <= operand_a;
                    req.b   <= RADIX_WORD;
                    req.sub <= 1'b0;
                end
            end
            calc_key_pkg::ENTER_B: begin
                if (key_strobe) begin
                    digit_q <= key_digit;
                    req.a   <= operand_b;
                    req.b   <= RADIX_WORD;
                    req.sub <= 1'b0;
                end
            end
            calc_key_pkg::ISSUE: begin
                req.a   <= operand_a;
                req.b   <= operand_b;
                req.sub <= (pend_op == calc_key_pkg::OP_SUB);
            end
            default: ;
        endcase
    end

    // the two units share one request bus
    a_one_start: assert property (@(posedge clk) disable iff (!nRST)
        !(start_addsub && start_mul));

    // only the unit we issued to may answer
    a_expected_done: assert property (@(posedge clk) disable iff (!nRST)
        (state == calc_key_pkg::WAIT_RESULT) |->
            !((wait_unit == calc_arith_pkg::UNIT_MUL) ? addsub_done : mul_done));

endmodule

// File: hdl/sm_addsub.sv
// sign-magnitude adder/subtractor with a registered result one cycle after start
`include "calc_defines.svh"

module sm_addsub (
    input  logic                       clk,
    input  logic                       nRST,
    input  logic                       start,
    input  calc_arith_pkg::arith_req_t req,
    output calc_arith_pkg::sm_word_t   sum,
    output logic                       done
);

    calc_arith_pkg::sm_word_t op_b;
    calc_arith_pkg::sm_word_t sum_d;

    always_comb begin
        // subtract is add with b negated
        op_b      = req.b;
        op_b.sign = req.b.sign ^ req.sub;

        if (req.a.sign == op_b.sign) begin
            sum_d.sign = req.a.sign;
            sum_d.mag  = req.a.mag + op_b.mag;
        end else if (req.a.mag >= op_b.mag) begin
            sum_d.sign = req.a.sign;
            sum_d.mag  = req.a.mag - op_b.mag;
        end else begin
            sum_d.sign = op_b.sign;
            sum_d.mag  = op_b.mag - req.a.mag;
        end

        // no negative zero
        if (sum_d.mag == '0)
            sum_d.sign = 1'b0;
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST)
            done <= 1'b0;
        else
            done <= start;
    end

    always_ff @(posedge clk) begin
        if (start)
            sum <= sum_d;
    end

    a_done_follows_start: assert property (@(posedge clk) disable iff (!nRST)
        start |=> done);

    // a zero sum or difference always leaves with a positive sign
    a_zero_positive: assert property (@(posedge clk) disable iff (!nRST)
        done |-> !(sum.sign && (sum.mag == '0)));

endmodule

// File: hdl/seq_multiplier.sv
// shift-and-add sign-magnitude multiplier, one multiplier bit per cycle
`include "calc_defines.svh"

module seq_multiplier (
    input  logic                       clk,
    input  logic                       nRST,
    input  logic                       start,
    input  calc_arith_pkg::arith_req_t req,
    output calc_arith_pkg::sm_word_t   product,
    output logic                       done
);

    logic                   running;
    logic                   sign_q;
    logic [`CALC_MAG_W-1:0] acc_q, mcand_q, mplier_q;

    logic                   sign_in;
    logic [`CALC_MAG_W-1:0] acc_in, mcand_in, mplier_in;
    logic [`CALC_MAG_W-1:0] acc_step, mplier_step;

    // first step works straight off the request
    always_comb begin
        if (start) begin
            sign_in   = req.a.sign ^ req.b.sign;
            acc_in    = '0;
            mcand_in  = req.a.mag;
            mplier_in = req.b.mag;
        end else begin
            sign_in   = sign_q;
            acc_in    = acc_q;
            mcand_in  = mcand_q;
            mplier_in = mplier_q;
        end
        acc_step    = mplier_in[0] ? acc_in + mcand_in : acc_in;
        mplier_step = mplier_in >> 1;
    end

    // stop once no multiplier bits remain
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start || running) begin
                running <= (mplier_step != '0);
                done    <= (mplier_step == '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || running) begin
            sign_q   <= sign_in;
            acc_q    <= acc_step;
            mcand_q  <= mcand_in << 1;
            mplier_q <= mplier_step;
            if (mplier_step == '0) begin
                // truncated to 15 bits, zero is positive
                product.sign <= sign_in & (acc_step != '0);
                product.mag  <= acc_step;
            end
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!nRST)
        running |-> !start);

    a_done_after_work: assert property (@(posedge clk) disable iff (!nRST)
        done |-> $past(start || running));

endmodule

// File: hdl/calc_top.sv
// calculator core top: entry controller with its adder and shared multiplier
`include "calc_defines.svh"

module calc_top (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     key_strobe,
    input  logic [`CALC_DIGIT_W-1:0] key_digit,
    input  calc_key_pkg::op_code_e   op_code,
    input  logic                     equal_strobe,
    output calc_arith_pkg::sm_word_t result,
    output logic                     complete,
    output logic                     busy
);

    calc_arith_pkg::arith_req_t req;
    calc_arith_pkg::sm_word_t   sum, product;
    logic                       start_addsub, addsub_done;
    logic                       start_mul, mul_done;

    calc_entry_ctrl ctrl_i (
        .clk          (clk),
        .nRST         (nRST),
        .key_strobe   (key_strobe),
        .key_digit    (key_digit),
        .op_code      (op_code),
        .equal_strobe (equal_strobe),
        .sum          (sum),
        .addsub_done  (addsub_done),
        .product      (product),
        .mul_done     (mul_done),
        .req          (req),
        .start_addsub (start_addsub),
        .start_mul    (start_mul),
        .result       (result),
        .complete     (complete),
        .busy         (busy)
    );

    sm_addsub addsub_i (
        .clk   (clk),
        .nRST  (nRST),
        .start (start_addsub),
        .req   (req),
        .sum   (sum),
        .done  (addsub_done)
    );

    // also scales operands during digit entry
    seq_multiplier mul_i (
        .clk     (clk),
        .nRST    (nRST),
        .start   (start_mul),
        .req     (req),
        .product (product),
        .done    (mul_done)
    );

endmodule

// File: sim/calc_tb.sv
// testbench for the calculator core: keys in operations from a vector file and checks results
`include "calc_defines.svh"

module calc_tb;

    typedef logic [`CALC_DIGIT_W-1:0] digit_t;

    // one line of the vector file
    typedef struct packed {
        logic [`CALC_MAG_W-1:0]   a_mag;
        logic                     a_neg;
        calc_key_pkg::op_code_e   op;
        logic [`CALC_MAG_W-1:0]   b_mag;
        logic                     b_neg;
        calc_arith_pkg::sm_word_t expected;
    } test_vec_t;

    logic                     clk;
    logic                     nRST;
    logic                     key_strobe;
    digit_t                   key_digit;
    calc_key_pkg::op_code_e   op_code;
    logic                     equal_strobe;
    calc_arith_pkg::sm_word_t result;
    logic                     complete;
    logic                     busy;

    test_vec_t vectors[$];
    bit        vectors_loaded;
    int        error_count;
    int        pass_count;

    calc_top calc_top_i (
        .clk          (clk),
        .nRST         (nRST),
        .key_strobe   (key_strobe),
        .key_digit    (key_digit),
        .op_code      (op_code),
        .equal_strobe (equal_strobe),
        .result       (result),
        .complete     (complete),
        .busy         (busy)
    );

    always #4 clk = ~clk;

    task automatic check_result(input string name, input calc_arith_pkg::sm_word_t actual,
                                input calc_arith_pkg::sm_word_t expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("Failure: %s", what);
            error_count++;
        end
    endtask

    // idle gap, then sample busy at the falling edge where state is settled
    task automatic wait_ready();
        repeat ($urandom_range(3, 0)) @(posedge clk);
        @(negedge clk);
        while (busy)
            @(negedge clk);
    endtask

    task automatic press_digit(input digit_t digit);
        wait_ready();
        @(posedge clk);
        key_strobe <= 1'b1;
        key_digit  <= digit;
        @(posedge clk);
        key_strobe <= 1'b0;
    endtask

    task automatic press_op(input calc_key_pkg::op_code_e op);
        wait_ready();
        @(posedge clk);
        op_code <= op;
        @(posedge clk);
        op_code <= calc_key_pkg::OP_NONE;
    endtask

    task automatic press_equal();
        wait_ready();
        @(posedge clk);
        equal_strobe <= 1'b1;
        @(posedge clk);
        equal_strobe <= 1'b0;
    endtask

    // most significant digit first, zero is a single zero key
    task automatic enter_operand(input logic [`CALC_MAG_W-1:0] mag, input logic neg);
        int unsigned rest;
        digit_t      digits[$];
        rest = mag;
        do begin
            digits.push_front(digit_t'(rest % `CALC_RADIX));
            rest = rest / `CALC_RADIX;
        end while (rest != 0);
        foreach (digits[i])
            press_digit(digits[i]);
        if (neg)
            press_op(calc_key_pkg::OP_NEG);
    endtask

    task automatic load_vectors();
        int          fd;
        string       line;
        int unsigned a_val, a_neg, op_val, b_val, b_neg, exp_val;
        test_vec_t   vec;
        fd = $fopen("sim/calc_input.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                // comment lines do not parse into six fields
                if ($sscanf(line, "%d %d %d %d %d %h",
                            a_val, a_neg, op_val, b_val, b_neg, exp_val) == 6) begin
                    vec.a_mag    = a_val[`CALC_MAG_W-1:0];
                    vec.a_neg    = a_neg[0];
                    vec.op       = calc_key_pkg::op_code_e'(op_val[2:0]);
                    vec.b_mag    = b_val[`CALC_MAG_W-1:0];
                    vec.b_neg    = b_neg[0];
                    vec.expected = calc_arith_pkg::sm_word_t'(exp_val[`CALC_DATA_W-1:0]);
                    vectors.push_back(vec);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int idx, input calc_arith_pkg::sm_word_t shown);
        test_vec_t                 vec;
        int                        errors_before;
        calc_arith_pkg::unit_sel_e unit;
        vec           = vectors[idx];
        errors_before = error_count;
        unit = (vec.op == calc_key_pkg::OP_MUL) ? calc_arith_pkg::UNIT_MUL
                                                : calc_arith_pkg::UNIT_ADDSUB;
        enter_operand(vec.a_mag, vec.a_neg);
        press_op(vec.op);
        enter_operand(vec.b_mag, vec.b_neg);
        // digit entry uses the multiplier but leaves the display alone
        wait_ready();
        check_result("result", result, shown);
        check_flag(complete, 1'b0, "complete pulsed before equal was pressed");
        press_equal();
        @(negedge clk);
        while (!complete)
            @(negedge clk);
        check_result("result", result, vec.expected);
        @(negedge clk);
        check_flag(complete, 1'b0, "complete stayed high for more than one cycle");
        check_result("result", result, vec.expected);
        if (error_count == errors_before)
            pass_count++;
        $display("test %0d: %s%0d %s %s%0d = %h on %s, %s", idx,
                 vec.a_neg ? "-" : "", vec.a_mag, vec.op.name(),
                 vec.b_neg ? "-" : "", vec.b_mag, vec.expected, unit.name(),
                 (error_count == errors_before) ? "ok" : "FAILED");
    endtask

    // bound the run by the number of tests
    initial begin
        wait (vectors_loaded);
        #((vectors.size() + 1) * 600 * 8);
        $display("timeout: the DUT stopped responding before all tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int unsigned              seed;
        calc_arith_pkg::sm_word_t shown;
        seed         = $urandom(32'hb65050ea);
        clk          = 1'b0;
        nRST         = 1'b0;
        key_strobe   = 1'b0;
        key_digit    = '0;
        op_code      = calc_key_pkg::OP_NONE;
        equal_strobe = 1'b0;
        error_count  = 0;
        pass_count   = 0;
        load_vectors();
        vectors_loaded = 1'b1;
        if (vectors.size() == 0) begin
            $display("no test vectors could be read from sim/calc_input.txt");
            error_count++;
        end

        repeat (8) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);
        check_flag(complete, 1'b0, "complete is high after reset");
        check_flag(busy, 1'b0, "busy is high after reset");
        check_result("result", result, '0);

        shown = '0;
        foreach (vectors[i]) begin
            run_test(i, shown);
            shown = vectors[i].expected;
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors", vectors.size(),
                 pass_count, vectors.size() - pass_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: sim/calc_input.txt
# a_mag a_neg op b_mag b_neg expected_hex
# op codes: 2 add, 3 subtract, 4 multiply; neg 1 presses NEG after the digits
123 0 2 456 0 0243
1000 1 2 250 0 82EE
250 0 3 1000 1 04E2
77 1 2 77 0 0000
500 1 3 500 1 0000
32000 0 2 1000 0 00E8
12 0 4 34 0 0198
25 1 4 40 0 83E8
25 1 4 40 1 03E8
0 0 4 999 1 0000
300 0 4 200 0 6A60
256 1 4 128 0 0000
7 0 2 0 0 0007
9 1 3 4 0 800D
4095 0 3 5000 0 8389
1234 0 2 4321 1 8C0F
181 0 4 181 0 7FF9
5 0 4 1 1 8005

// File: calc_top.f
+incdir+include
hdl/calc_key_pkg.sv
hdl/calc_arith_pkg.sv
hdl/calc_entry_ctrl.sv
hdl/sm_addsub.sv
hdl/seq_multiplier.sv
hdl/calc_top.sv
sim/calc_tb.sv

// File: Makefile
TB = calc_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f calc_top.f --top-module $(TB)

run: build
	./obj_dir/V$(TB) | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f calc_top.f --top-module calc_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
